//--- tests/lcd_patterns.txt
// op_rs_arg_data: op 1 write, 2 read and compare, 3 poll until idle, 0 end
// op 4 expect byte, op 5 expect nibble; arg is the address, or a repeat count
2_0_21_01  // status busy, not ready
5_0_03_03  // wake nibbles
5_0_01_02
4_0_01_28
4_0_01_06
4_0_01_0c
4_0_01_01
4_0_01_80  // first refresh, blank buffer
4_1_10_20
4_0_01_c0
4_1_10_20
3_0_00_00
2_0_21_02  // ready, idle
1_0_00_48
1_0_01_69
1_0_10_4f
1_0_11_4b
2_0_00_48
2_0_11_4b
2_0_3f_00  // unmapped
1_0_20_01  // start refresh
1_0_00_58  // while busy, dropped
2_0_00_48
4_0_01_80
4_1_01_48
4_1_01_69
4_1_0e_20
4_0_01_c0
4_1_01_4f
4_1_01_4b
4_1_0e_20
3_0_00_00
0_0_00_00

//--- lcd_ctrl.f
hw/lcd_pkg.sv
hw/lcd_bus_writer.sv
hw/lcd_sequencer.sv
hw/lcd_wb_regs.sv
hw/lcd_ctrl_top.sv
tests/lcd_clk_gen.sv
tests/tb_lcd_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the LCD controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_lcd_ctrl -f lcd_ctrl.f -Mdir obj_dir \
    && ./obj_dir/Vtb_lcd_ctrl | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -q "test failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "test passed" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0

//--- tests/tb_lcd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_ctrl;
    import lcd_pkg::*;

    localparam int T_POWER      = 40;
    localparam int T_WAKE1      = 20;
    localparam int T_WAKE2      = 10;
    localparam int T_CMD        = 8;
    localparam int T_CLEAR      = 16;
    localparam int T_E_PULSE    = 3;
    localparam int T_NIBBLE_GAP = 4;
    localparam int WAIT_LIMIT   = 1000;  // cycles per wait
    localparam int POLL_LIMIT   = 500;   // status reads per poll
    localparam int PAT_DEPTH    = 64;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    logic        lcd_e;
    logic        lcd_rs;
    nibble_t     lcd_data;
    int          errors;
    logic        timed_out;            // a wait ran out
    logic [9:0]  lcd_q [$];            // {nibble flag, rs, value}
    logic [23:0] pat [PAT_DEPTH];      // op, rs, addr or count, data

    lcd_clk_gen clk_gen_i (.clk, .rst);

    lcd_ctrl_top #(
        .T_POWER(T_POWER), .T_WAKE1(T_WAKE1), .T_WAKE2(T_WAKE2), .T_CMD(T_CMD),
        .T_CLEAR(T_CLEAR), .T_E_PULSE(T_E_PULSE), .T_NIBBLE_GAP(T_NIBBLE_GAP)
    ) dut_i (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .lcd_e, .lcd_rs, .lcd_data
    );

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        errors++;
        $display("timeout: %s", what);
    endtask

    // ----------------------------------------------------------------------
    // host side
    // ----------------------------------------------------------------------
    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dw,
                             output wb_data_t dr);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dw;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < WAIT_LIMIT);
        if (!wb_ack) begin
            report_timeout("no wb_ack for a bus access");
        end else begin
            dr     = wb_dat_r;  // valid with ack
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            @(negedge clk);
            compare("wb_ack", 32'(wb_ack), 0);  // single ack cycle
        end
    endtask

    task automatic poll_idle();
        wb_data_t st;
        int       n;
        n = 0;
        do begin
            wb_access(1'b0, REG_STATUS, 8'h00, st);
            n++;
        end while (!timed_out && st[0] && n < POLL_LIMIT);
        if (!timed_out && st[0]) begin
            report_timeout("status busy bit never cleared");
        end
    endtask

    task automatic expect_lcd(input logic nib, input logic rs, input int count,
                              input lcd_byte_t val);
        logic [9:0] got;
        int         n;
        for (int k = 0; k < count && !timed_out; k++) begin
            n = 0;
            while (lcd_q.size() == 0 && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (lcd_q.size() == 0) begin
                report_timeout("no LCD transfer arrived");
            end else begin
                got = lcd_q.pop_front();
                compare("lcd {nibble,rs,value}", 32'(got), 32'({nib, rs, val}));
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // LCD monitor sampled on falling clk
    // ----------------------------------------------------------------------
    int      hi_cnt;
    int      lo_cnt;
    int      nib_seen;    // start-up nibbles come unpaired
    logic    e_prev;
    logic    hi_rs;
    logic    have_upper;
    nibble_t hi_data;
    nibble_t upper;

    always @(negedge clk) begin
        if (rst) begin
            hi_cnt     = 0;
            lo_cnt     = 0;
            nib_seen   = 0;
            e_prev     = 1'b0;
            have_upper = 1'b0;
        end else if (lcd_e) begin
            if (!e_prev) begin
                if (have_upper) compare("lcd_e low gap", lo_cnt, T_NIBBLE_GAP);
                hi_cnt  = 1;
                hi_data = lcd_data;
                hi_rs   = lcd_rs;
            end else begin
                hi_cnt++;
                compare("lcd_data", 32'(lcd_data), 32'(hi_data));  // held while e high
                compare("lcd_rs", 32'(lcd_rs), 32'(hi_rs));
            end
            e_prev = 1'b1;
        end else begin
            if (e_prev) begin  // falling edge of lcd_e
                compare("lcd_e high cycles", hi_cnt, T_E_PULSE);
                if (nib_seen < 4) begin
                    lcd_q.push_back({1'b1, hi_rs, 4'h0, hi_data});
                    nib_seen++;
                end else if (!have_upper) begin
                    upper      = hi_data;
                    have_upper = 1'b1;
                end else begin
                    lcd_q.push_back({1'b0, hi_rs, upper, hi_data});
                    have_upper = 1'b0;
                end
                lo_cnt = 1;
            end else begin
                lo_cnt++;
            end
            e_prev = 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // pattern replay
    // ----------------------------------------------------------------------
    initial begin
        logic [23:0] rec;
        wb_data_t    rd;
        int          idx;
        int          n;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        errors    = 0;
        timed_out = 1'b0;
        $readmemh("tests/lcd_patterns.txt", pat);
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            report_timeout("reset never released");
        end else begin
            compare("lcd_e", 32'(lcd_e), 0);  // quiet bus after reset
            compare("wb_ack", 32'(wb_ack), 0);
            idx = 0;
            while (!timed_out && idx < PAT_DEPTH && pat[idx][23:20] != 4'h0) begin
                rec = pat[idx];
                case (rec[23:20])
                    4'h1: wb_access(1'b1, rec[13:8], rec[7:0], rd);
                    4'h2: begin
                        wb_access(1'b0, rec[13:8], 8'h00, rd);
                        if (!timed_out) compare("wb_dat_r", 32'(rd), 32'(rec[7:0]));
                    end
                    4'h3: poll_idle();
                    4'h4: expect_lcd(1'b0, rec[16], 32'(rec[15:8]), rec[7:0]);
                    4'h5: expect_lcd(1'b1, rec[16], 32'(rec[15:8]), rec[7:0]);
                    default: begin
                        errors++;
                        $display("unknown record %h at line index %0d", rec, idx);
                    end
                endcase
                idx++;
            end
            if (!timed_out) begin
                assert (lcd_q.size() == 0) else begin
                    errors++;
                    $display("%0d LCD transfers arrived that no record expected", lcd_q.size());
                end
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/lcd_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_clk_gen #(
    parameter int HALF_PERIOD = 2,   // 4 ns clock
    parameter int RST_CYCLES  = 3
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released on a falling edge like all stimulus
    end

endmodule

`default_nettype wire

//--- hw/lcd_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_ctrl_top #(
    parameter int unsigned T_POWER      = 750000,  // power-up
    parameter int unsigned T_WAKE1      = 205000,
    parameter int unsigned T_WAKE2      = 500,
    parameter int unsigned T_CMD        = 2000,    // ordinary command
    parameter int unsigned T_CLEAR      = 82000,   // clear display
    parameter int unsigned T_E_PULSE    = 12,
    parameter int unsigned T_NIBBLE_GAP = 50
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  lcd_pkg::wb_addr_t wb_adr,
    input  lcd_pkg::wb_data_t wb_dat_w,
    output lcd_pkg::wb_data_t wb_dat_r,
    output logic              wb_ack,
    output logic              lcd_e,
    output logic              lcd_rs,
    output lcd_pkg::nibble_t  lcd_data
);
    import lcd_pkg::*;

    logic      busy, ready, refresh_req;
    char_idx_t char_idx;
    lcd_byte_t char_data;
    logic      wr_start, wr_done, wr_rs, wr_nibble_only;
    lcd_byte_t wr_byte;

    // ----------------------------------------------------------------------
    // host side, buffer and status
    // ----------------------------------------------------------------------
    lcd_wb_regs regs_i (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .busy, .ready, .char_idx,
        .wb_dat_r, .wb_ack, .refresh_req, .char_data
    );

    lcd_sequencer #(
        .T_POWER(T_POWER), .T_WAKE1(T_WAKE1), .T_WAKE2(T_WAKE2), .T_CMD(T_CMD)
    ) seq_i (
        .clk, .rst, .refresh_req, .wr_done, .char_data,
        .busy, .ready, .char_idx, .wr_start, .wr_rs, .wr_nibble_only, .wr_byte
    );

    // LCD pin driver
    lcd_bus_writer #(
        .T_E_PULSE(T_E_PULSE), .T_NIBBLE_GAP(T_NIBBLE_GAP),
        .T_CMD(T_CMD), .T_CLEAR(T_CLEAR)
    ) wr_i (
        .clk, .rst, .wr_start, .wr_rs, .wr_nibble_only, .wr_byte,
        .wr_done, .lcd_e, .lcd_rs, .lcd_data
    );

endmodule

`default_nettype wire

//--- hw/lcd_wb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_wb_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  lcd_pkg::wb_addr_t  wb_adr,
    input  lcd_pkg::wb_data_t  wb_dat_w,
    input  logic               busy,       // from sequencer
    input  logic               ready,
    input  lcd_pkg::char_idx_t char_idx,
    output lcd_pkg::wb_data_t  wb_dat_r,   // valid with wb_ack
    output logic               wb_ack,
    output logic               refresh_req,
    output lcd_pkg::lcd_byte_t char_data
);
    import lcd_pkg::*;

    lcd_byte_t text_buf [TEXT_LEN];  // row 0 then row 1
    logic      acc;                  // new access this cycle
    logic      wr_ok;                // write allowed
    logic      text_hit;
    wb_addr_t  txt_off;
    wb_data_t  rd_mux;

    assign acc      = wb_cyc && wb_stb && !wb_ack;
    assign wr_ok    = acc && wb_we && !busy;
    assign txt_off  = wb_adr - REG_TEXT_BASE;
    assign text_hit = txt_off < wb_addr_t'(TEXT_LEN);

    // sequencer reads straight out of the buffer
    assign char_data = text_buf[char_idx];

    // ----------------------------------------------------------------------
    // read decode
    // ----------------------------------------------------------------------
    always_comb begin
        if (text_hit) begin
            rd_mux = text_buf[char_idx_t'(txt_off)];
        end else if (wb_adr == REG_STATUS) begin
            rd_mux = {6'b0, ready, busy};
        end else begin
            rd_mux = '0;  // ctrl and unmapped
        end
    end

    // ----------------------------------------------------------------------
    // bus handshake and refresh strobe
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            wb_dat_r    <= '0;
            refresh_req <= 1'b0;
        end else begin
            wb_ack      <= acc;  // one cycle, stb is dropped after it
            refresh_req <= 1'b0;
            if (acc && !wb_we) begin
                wb_dat_r <= rd_mux;
            end
            if (wr_ok && wb_adr == REG_CTRL && wb_dat_w[0]) begin
                refresh_req <= 1'b1;  // ignored while busy
            end
        end
    end

    // ----------------------------------------------------------------------
    // text buffer, blank on reset
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < TEXT_LEN; i++) begin
                text_buf[i] <= 8'h20;  // space
            end
        end else if (wr_ok && text_hit) begin
            text_buf[char_idx_t'(txt_off)] <= wb_dat_w;
        end
    end

endmodule

`default_nettype wire

//--- hw/lcd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_sequencer #(
    parameter int unsigned T_POWER = 750000,
    parameter int unsigned T_WAKE1 = 205000,
    parameter int unsigned T_WAKE2 = 500,
    parameter int unsigned T_CMD   = 2000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               refresh_req,     // from register block
    input  logic               wr_done,
    input  lcd_pkg::lcd_byte_t char_data,       // buffer read at char_idx
    output logic               busy,
    output logic               ready,           // configuration done
    output lcd_pkg::char_idx_t char_idx,
    output logic               wr_start,
    output logic               wr_rs,
    output logic               wr_nibble_only,
    output lcd_pkg::lcd_byte_t wr_byte
);
    import lcd_pkg::*;

    seq_state_t state;
    dly_cnt_t   cnt;
    logic [2:0] step;       // 0..3 wake nibbles, 4..7 config bytes
    lcd_byte_t  init_byte;
    dly_cnt_t   wake_dly;

    // ----------------------------------------------------------------------
    // start-up tables
    // ----------------------------------------------------------------------
    always_comb begin
        case (step)
            3'd0, 3'd1, 3'd2: init_byte = {4'h0, NIB_WAKE};
            3'd3:             init_byte = {4'h0, NIB_4BIT};
            3'd4:             init_byte = CMD_FUNC_SET;
            3'd5:             init_byte = CMD_ENTRY_MODE;
            3'd6:             init_byte = CMD_DISP_ON;
            default:          init_byte = CMD_CLEAR;
        endcase
    end

    always_comb begin
        case (step[1:0])
            2'd0:    wake_dly = dly_cnt_t'(T_WAKE1 - 1);  // after first 0x3
            2'd1:    wake_dly = dly_cnt_t'(T_WAKE2 - 1);  // after second
            default: wake_dly = dly_cnt_t'(T_CMD - 1);    // third and 0x2
        endcase
    end

    // ----------------------------------------------------------------------
    // sequence FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= S_PWR;
            cnt            <= dly_cnt_t'(T_POWER - 1);
            step           <= '0;
            char_idx       <= '0;
            busy           <= 1'b1;  // held through the first refresh
            ready          <= 1'b0;
            wr_start       <= 1'b0;
            wr_rs          <= 1'b0;
            wr_nibble_only <= 1'b0;
            wr_byte        <= '0;
        end else begin
            wr_start <= 1'b0;  // pulse
            case (state)
                S_PWR: begin
                    if (cnt == '0) begin
                        state <= S_INIT_SEND;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_INIT_SEND: begin
                    wr_start       <= 1'b1;
                    wr_rs          <= 1'b0;
                    wr_nibble_only <= ~step[2];  // first four are bare nibbles
                    wr_byte        <= init_byte;
                    state          <= S_INIT_ACK;
                end
                S_INIT_ACK: begin
                    if (wr_done) begin
                        if (!step[2]) begin
                            cnt   <= wake_dly;
                            state <= S_INIT_DLY;
                        end else if (step == 3'd7) begin
                            ready <= 1'b1;  // clear sent, go straight to refresh
                            state <= S_ADDR_SEND;
                        end else begin
                            step  <= step + 3'd1;
                            state <= S_INIT_SEND;
                        end
                    end
                end
                S_INIT_DLY: begin
                    if (cnt == '0) begin
                        step  <= step + 3'd1;
                        state <= S_INIT_SEND;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_IDLE: begin
                    if (refresh_req) begin
                        busy  <= 1'b1;
                        state <= S_ADDR_SEND;
                    end
                end
                S_ADDR_SEND: begin
                    wr_start       <= 1'b1;
                    wr_rs          <= 1'b0;
                    wr_nibble_only <= 1'b0;
                    wr_byte        <= (char_idx < char_idx_t'(ROW_LEN)) ? ROW0_ADDR
                                                                         : ROW1_ADDR;
                    state          <= S_ADDR_ACK;
                end
                S_ADDR_ACK: if (wr_done) state <= S_CHAR_SEND;
                S_CHAR_SEND: begin
                    wr_start       <= 1'b1;
                    wr_rs          <= 1'b1;       // data register
                    wr_nibble_only <= 1'b0;
                    wr_byte        <= char_data;  // writer latches it
                    state          <= S_CHAR_ACK;
                end
                S_CHAR_ACK: begin
                    if (wr_done) begin
                        if (char_idx == char_idx_t'(TEXT_LEN - 1)) begin
                            char_idx <= '0;
                            busy     <= 1'b0;  // refresh finished
                            state    <= S_IDLE;
                        end else begin
                            char_idx <= char_idx + 1'b1;
                            // row 1 address goes in after index 15
                            state    <= (char_idx == char_idx_t'(ROW_LEN - 1)) ? S_ADDR_SEND
                                                                                : S_CHAR_SEND;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/lcd_bus_writer.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_bus_writer #(
    parameter int unsigned T_E_PULSE    = 12,
    parameter int unsigned T_NIBBLE_GAP = 50,
    parameter int unsigned T_CMD        = 2000,
    parameter int unsigned T_CLEAR      = 82000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_start,        // one-cycle request
    input  logic               wr_rs,
    input  logic               wr_nibble_only,  // low nibble of wr_byte only
    input  lcd_pkg::lcd_byte_t wr_byte,
    output logic               wr_done,         // one-cycle pulse
    output logic               lcd_e,
    output logic               lcd_rs,
    output lcd_pkg::nibble_t   lcd_data
);
    import lcd_pkg::*;

    wr_state_t state;
    dly_cnt_t  cnt;         // counts down to 0
    lcd_byte_t byte_q;      // latched request
    logic      nib_only_q;
    logic      lo_phase;    // lower nibble on the bus
    dly_cnt_t  post_dly;

    // clear needs the long wait, everything else the short one
    assign post_dly = (!lcd_rs && byte_q == CMD_CLEAR) ? dly_cnt_t'(T_CLEAR - 1)
                                                       : dly_cnt_t'(T_CMD - 1);

    always_ff @(posedge clk) begin
        if (state == W_IDLE && wr_start) begin
            byte_q     <= wr_byte;
            nib_only_q <= wr_nibble_only;
        end
    end

    // ----------------------------------------------------------------------
    // pulse FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= W_IDLE;
            cnt      <= '0;
            lo_phase <= 1'b0;
            wr_done  <= 1'b0;
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= '0;
        end else begin
            wr_done <= 1'b0;  // pulse
            case (state)
                W_IDLE: begin
                    if (wr_start) begin
                        lcd_rs   <= wr_rs;
                        lcd_data <= wr_nibble_only ? wr_byte[3:0] : wr_byte[7:4];
                        lcd_e    <= 1'b1;  // data and e move together
                        cnt      <= dly_cnt_t'(T_E_PULSE - 1);
                        lo_phase <= 1'b0;
                        state    <= W_E_HI;
                    end
                end
                W_E_HI: begin
                    if (cnt == '0) begin
                        lcd_e <= 1'b0;  // falling edge latches the nibble
                        if (nib_only_q) begin
                            wr_done <= 1'b1;  // wake nibbles, caller times the wait
                            state   <= W_IDLE;
                        end else if (!lo_phase) begin
                            cnt   <= dly_cnt_t'(T_NIBBLE_GAP - 1);
                            state <= W_GAP;
                        end else begin
                            cnt   <= post_dly;
                            state <= W_POST;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                W_GAP: begin
                    if (cnt == '0) begin
                        lcd_data <= byte_q[3:0];  // lower nibble
                        lcd_e    <= 1'b1;
                        cnt      <= dly_cnt_t'(T_E_PULSE - 1);
                        lo_phase <= 1'b1;
                        state    <= W_E_HI;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                W_POST: begin
                    if (cnt == '0) begin
                        wr_done <= 1'b1;
                        state   <= W_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    typedef logic [3:0]  nibble_t;     // one 4-bit bus transfer
    typedef logic [7:0]  lcd_byte_t;   // command or character code
    typedef logic [4:0]  char_idx_t;   // text buffer index
    typedef logic [5:0]  wb_addr_t;    // register address
    typedef logic [7:0]  wb_data_t;    // register data
    typedef logic [19:0] dly_cnt_t;    // covers the 750000-cycle power-up

    // ----------------------------------------------------------------------
    // buffer geometry
    // ----------------------------------------------------------------------
    localparam int TEXT_LEN = 32;      // two rows
    localparam int ROW_LEN  = 16;      // chars per row

    // ----------------------------------------------------------------------
    // HD44780 codes
    // ----------------------------------------------------------------------
    localparam nibble_t   NIB_WAKE       = 4'h3;   // 8-bit wake, sent three times
    localparam nibble_t   NIB_4BIT       = 4'h2;   // switch to 4-bit bus
    localparam lcd_byte_t CMD_FUNC_SET   = 8'h28;  // 4-bit, 2 lines, 5x8
    localparam lcd_byte_t CMD_ENTRY_MODE = 8'h06;  // increment, no shift
    localparam lcd_byte_t CMD_DISP_ON    = 8'h0C;  // display on, cursor off
    localparam lcd_byte_t CMD_CLEAR      = 8'h01;  // slow one
    localparam lcd_byte_t ROW0_ADDR      = 8'h80;  // ddram 0x00
    localparam lcd_byte_t ROW1_ADDR      = 8'hC0;  // ddram 0x40

    // ----------------------------------------------------------------------
    // register map
    // ----------------------------------------------------------------------
    localparam wb_addr_t REG_TEXT_BASE = 6'd0;   // 32 text bytes
    localparam wb_addr_t REG_CTRL      = 6'd32;  // bit 0 starts a refresh
    localparam wb_addr_t REG_STATUS    = 6'd33;  // bit 0 busy, bit 1 ready

    // ----------------------------------------------------------------------
    // state machines
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        S_PWR,          // power-up wait
        S_INIT_SEND,    // wake nibble or config byte
        S_INIT_ACK,
        S_INIT_DLY,     // wait after a wake nibble
        S_IDLE,
        S_ADDR_SEND,    // row address
        S_ADDR_ACK,
        S_CHAR_SEND,
        S_CHAR_ACK
    } seq_state_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_E_HI,         // enable pulse
        W_GAP,          // low time between nibbles
        W_POST          // command execution wait
    } wr_state_t;

endpackage

`default_nettype wire
